/* Bender.yml */
package:
  name: scoreboard

sources:
  - include_dirs:
      - .
    files:
      - scb_pkg.sv
      - scb_slot_table.sv
      - scb_issue.sv
      - scb_hazard.sv
      - scb_flush.sv
      - scoreboard.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - scoreboard_tb.sv

/* all.f */
+incdir+.
scb_pkg.sv
scb_slot_table.sv
scb_issue.sv
scb_hazard.sv
scb_flush.sv
scoreboard.sv
tb_clk_gen.sv
scoreboard_tb.sv

/* scb_cfg.svh */
`ifndef SCB_CFG_SVH
`define SCB_CFG_SVH

// sid index bits, one wrap bit sits above them
`define SCB_SID_IDX_W 3
`define SCB_REG_W 5

// decoder execution unit class, one-hot
`define SCB_EXE_UNIT_W 6
`define SCB_EU_ALU 0
`define SCB_EU_BEU 1
`define SCB_EU_LSU 2

`define SCB_NUM_SLOTS 4

`endif

/* scb_flush.sv */
`timescale 1ns/100ps

module scb_flush
    import scb_pkg::*;
(
    input  redirect_t redirect_i,
    input  sid_t      dec_sid0_i,
    input  sid_t      dec_sid1_i,
    input  op_inst_t  op0_i,
    input  op_inst_t  op1_i,
    input  wb_inst_t  wb0_i,
    input  wb_inst_t  wb1_i,
    output logic      dec_flush0_o,
    output logic      dec_flush1_o,
    output logic      op_flush0_o,
    output logic      op_flush1_o,
    output logic      wb_flush0_o,
    output logic      wb_flush1_o
);

    // anything younger than the redirecting instruction is squashed
    function automatic logic squash(input redirect_t r, input sid_t s);
        return r.vld && sid_newer(s, r.sid);
    endfunction

    assign dec_flush0_o = squash(redirect_i, dec_sid0_i);
    assign dec_flush1_o = squash(redirect_i, dec_sid1_i);
    assign op_flush0_o  = squash(redirect_i, op0_i.sid);
    assign op_flush1_o  = squash(redirect_i, op1_i.sid);
    assign wb_flush0_o  = squash(redirect_i, wb0_i.sid);
    assign wb_flush1_o  = squash(redirect_i, wb1_i.sid);

endmodule

/* scb_hazard.sv */
`timescale 1ns/100ps
`include "scb_cfg.svh"

module scb_hazard
    import scb_pkg::*;
(
    input  slot_t [`SCB_NUM_SLOTS-1:0]   slots_i,
    input  op_inst_t                     op0_i,
    input  op_inst_t                     op1_i,
    input  wb_inst_t                     wb0_i,
    input  wb_inst_t                     wb1_i,
    output logic                         op_stall0_o,
    output logic                         op_stall1_o,
    output logic                         wb_stall0_o,
    output logic                         wb_stall1_o
);

    logic raw_slot0;
    logic raw_slot1;
    logic raw_cross0;
    logic raw_cross1;

    // an older in-flight producer of rs1 or rs2
    function automatic logic raw_slots(input op_inst_t op,
                                       input slot_t [`SCB_NUM_SLOTS-1:0] s);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `SCB_NUM_SLOTS; i++) begin
            if (s[i].busy && (s[i].rd == op.rs1 || s[i].rd == op.rs2) &&
                sid_newer(op.sid, s[i].sid)) begin
                hit = 1'b1;
            end
        end
        return op.vld && hit;
    endfunction

    // the other operand lane is older and writes a source
    function automatic logic raw_pair(input op_inst_t me, input op_inst_t other);
        return me.vld && other.vld &&
               (other.rd == me.rs1 || other.rd == me.rs2) &&
               sid_newer(me.sid, other.sid);
    endfunction

    // same rd on both write-back lanes, younger one waits
    function automatic logic wb_pair(input wb_inst_t me, input wb_inst_t other);
        return me.vld && other.vld && me.rd == other.rd && sid_newer(me.sid, other.sid);
    endfunction

    assign raw_slot0  = raw_slots(op0_i, slots_i);
    assign raw_slot1  = raw_slots(op1_i, slots_i);
    assign raw_cross0 = raw_pair(op0_i, op1_i);
    assign raw_cross1 = raw_pair(op1_i, op0_i);

    assign op_stall0_o = raw_slot0 || raw_cross0;
    assign op_stall1_o = raw_slot1 || raw_cross1;

    assign wb_stall0_o = wb_pair(wb0_i, wb1_i);
    assign wb_stall1_o = wb_pair(wb1_i, wb0_i);

endmodule

/* scb_issue.sv */
`timescale 1ns/100ps
`include "scb_cfg.svh"

module scb_issue
    import scb_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  dec_inst_t                    dec0_i,
    input  dec_inst_t                    dec1_i,
    input  slot_t [`SCB_NUM_SLOTS-1:0]   slots_i,
    output unit_vec_t                    alloc0_o,
    output unit_vec_t                    alloc1_o,
    output sid_t                         sid0_o,
    output sid_t                         sid1_o,
    output logic                         dec_stall0_o,
    output logic                         dec_stall1_o
);

    unit_vec_t busy;
    unit_vec_t avail0;
    unit_vec_t avail1;
    logic      waw0;
    logic      waw1;
    logic      lane0_clear;
    logic      same_rd;
    sid_t      sid_q;

    // one slot for the lane's class out of the available ones
    function automatic unit_vec_t pick_unit(input dec_inst_t d, input unit_vec_t avail);
        unit_vec_t g;
        g = '0;
        if (d.vld) begin
            if (d.exe_unit[`SCB_EU_ALU]) begin
                if (avail[SLOT_ALU0]) begin
                    g[SLOT_ALU0] = 1'b1;
                end else if (avail[SLOT_ALU1]) begin
                    g[SLOT_ALU1] = 1'b1;
                end
            end else if (d.exe_unit[`SCB_EU_BEU]) begin
                g[SLOT_BEU] = avail[SLOT_BEU];
            end else if (d.exe_unit[`SCB_EU_LSU]) begin
                g[SLOT_LSU] = avail[SLOT_LSU];
            end
        end
        return g;
    endfunction

    function automatic logic waw_hit(input logic [`SCB_REG_W-1:0] rd,
                                     input slot_t [`SCB_NUM_SLOTS-1:0] s);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < `SCB_NUM_SLOTS; i++) begin
            if (s[i].busy && s[i].rd == rd) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    for (genvar i = 0; i < `SCB_NUM_SLOTS; i++) begin : g_busy
        assign busy[i] = slots_i[i].busy;
    end

    assign waw0 = waw_hit(dec0_i.rd, slots_i);
    assign waw1 = waw_hit(dec1_i.rd, slots_i);

    assign avail0   = ~busy;
    assign alloc0_o = waw0 ? '0 : pick_unit(dec0_i, avail0);

    // lane1 never takes what lane0 just took
    assign avail1      = ~busy & ~alloc0_o;
    assign lane0_clear = !dec0_i.vld || (|alloc0_o);
    assign same_rd     = dec0_i.vld && dec0_i.rd == dec1_i.rd;
    assign alloc1_o    = (waw1 || !lane0_clear || same_rd) ? '0 : pick_unit(dec1_i, avail1);

    assign sid0_o = sid_q;
    assign sid1_o = sid_t'(sid_q + 1'b1);

    assign dec_stall0_o = dec0_i.vld && !(|alloc0_o);
    assign dec_stall1_o = dec1_i.vld && !(|alloc1_o);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sid_q <= '0;
        end else if (|alloc1_o) begin
            // lane1 always uses counter+1, so two ids are gone
            sid_q <= sid_t'(sid_q + 2'd2);
        end else if (|alloc0_o) begin
            sid_q <= sid_t'(sid_q + 1'b1);
        end
    end

    a_grant_onehot: assert property (@(posedge clk) disable iff (!rst_n)
        $onehot0(alloc0_o) && $onehot0(alloc1_o));

endmodule

/* scb_pkg.sv */
`include "scb_cfg.svh"

package scb_pkg;

    typedef struct packed {
        logic                      wrap;
        logic [`SCB_SID_IDX_W-1:0] idx;
    } sid_t;

    // slot order inside every slot vector
    typedef enum logic [1:0] {
        SLOT_ALU0,
        SLOT_ALU1,
        SLOT_BEU,
        SLOT_LSU
    } slot_id_e;

    typedef logic [`SCB_NUM_SLOTS-1:0] unit_vec_t;

    typedef struct packed {
        logic                       vld;
        logic [`SCB_EXE_UNIT_W-1:0] exe_unit;
        logic [`SCB_REG_W-1:0]      rd;
        logic [`SCB_REG_W-1:0]      rs1;
        logic [`SCB_REG_W-1:0]      rs2;
    } dec_inst_t;

    typedef struct packed {
        logic                  vld;
        sid_t                  sid;
        logic [`SCB_REG_W-1:0] rd;
        logic [`SCB_REG_W-1:0] rs1;
        logic [`SCB_REG_W-1:0] rs2;
    } op_inst_t;

    typedef struct packed {
        logic                  vld;
        sid_t                  sid;
        logic [`SCB_REG_W-1:0] rd;
    } wb_inst_t;

    typedef struct packed {
        logic vld;
        sid_t sid;
    } redirect_t;

    typedef struct packed {
        logic                  busy;
        logic [`SCB_REG_W-1:0] rd;
        logic [`SCB_REG_W-1:0] rs1;
        logic [`SCB_REG_W-1:0] rs2;
        sid_t                  sid;
    } slot_t;

    // a younger than b, the wrap bit flips the index order
    function automatic logic sid_newer(input sid_t a, input sid_t b);
        if (a.wrap == b.wrap) begin
            return a.idx > b.idx;
        end else begin
            return a.idx < b.idx;
        end
    endfunction

endpackage

/* scb_slot_table.sv */
`timescale 1ns/100ps
`include "scb_cfg.svh"

module scb_slot_table
    import scb_pkg::*;
(
    input  logic                         clk,
    input  logic                         rst_n,
    input  unit_vec_t                    alloc0_i,
    input  unit_vec_t                    alloc1_i,
    input  dec_inst_t                    dec0_i,
    input  dec_inst_t                    dec1_i,
    input  sid_t                         sid0_i,
    input  sid_t                         sid1_i,
    input  wb_inst_t                     wb0_i,
    input  wb_inst_t                     wb1_i,
    input  logic                         wb_stall0_i,
    input  logic                         wb_stall1_i,
    output slot_t [`SCB_NUM_SLOTS-1:0]   slots_o
);

    unit_vec_t             busy_q;
    unit_vec_t             release_vec;
    logic [`SCB_REG_W-1:0] rd_q  [`SCB_NUM_SLOTS];
    logic [`SCB_REG_W-1:0] rs1_q [`SCB_NUM_SLOTS];
    logic [`SCB_REG_W-1:0] rs2_q [`SCB_NUM_SLOTS];
    sid_t                  sid_q [`SCB_NUM_SLOTS];

    for (genvar i = 0; i < `SCB_NUM_SLOTS; i++) begin : g_slot
        // retired by a write-back lane that is not held back
        assign release_vec[i] = (wb0_i.vld && !wb_stall0_i && wb0_i.sid == sid_q[i]) ||
                                (wb1_i.vld && !wb_stall1_i && wb1_i.sid == sid_q[i]);

        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                busy_q[i] <= 1'b0;
            end else if (alloc0_i[i] || alloc1_i[i]) begin
                busy_q[i] <= 1'b1;
            end else if (release_vec[i]) begin
                busy_q[i] <= 1'b0;
            end
        end

        // lane0 first
        always_ff @(posedge clk) begin
            if (alloc0_i[i]) begin
                rd_q[i]  <= dec0_i.rd;
                rs1_q[i] <= dec0_i.rs1;
                rs2_q[i] <= dec0_i.rs2;
                sid_q[i] <= sid0_i;
            end else if (alloc1_i[i]) begin
                rd_q[i]  <= dec1_i.rd;
                rs1_q[i] <= dec1_i.rs1;
                rs2_q[i] <= dec1_i.rs2;
                sid_q[i] <= sid1_i;
            end
        end

        assign slots_o[i] = '{
            busy: busy_q[i],
            rd:   rd_q[i],
            rs1:  rs1_q[i],
            rs2:  rs2_q[i],
            sid:  sid_q[i]
        };
    end

    // issue only grants slots that are free in this table
    a_alloc_free: assert property (@(posedge clk) disable iff (!rst_n)
        ((alloc0_i | alloc1_i) & busy_q) == '0);

    a_alloc_disjoint: assert property (@(posedge clk) disable iff (!rst_n)
        (alloc0_i & alloc1_i) == '0);

endmodule

/* scoreboard.sv */
`timescale 1ns/100ps
`include "scb_cfg.svh"

module scoreboard
    import scb_pkg::*;
(
    input  logic      clk,
    input  logic      rst_n,
    input  dec_inst_t dec0_i,
    input  dec_inst_t dec1_i,
    input  op_inst_t  op0_i,
    input  op_inst_t  op1_i,
    input  wb_inst_t  wb0_i,
    input  wb_inst_t  wb1_i,
    input  redirect_t redirect_i,
    output unit_vec_t dec_grant0_o,
    output unit_vec_t dec_grant1_o,
    output sid_t      dec_sid0_o,
    output sid_t      dec_sid1_o,
    output logic      dec_stall0_o,
    output logic      dec_stall1_o,
    output logic      dec_flush0_o,
    output logic      dec_flush1_o,
    output logic      op_stall0_o,
    output logic      op_stall1_o,
    output logic      op_flush0_o,
    output logic      op_flush1_o,
    output logic      wb_stall0_o,
    output logic      wb_stall1_o,
    output logic      wb_flush0_o,
    output logic      wb_flush1_o
);

    slot_t [`SCB_NUM_SLOTS-1:0] slots;

    scb_slot_table u_slot_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .alloc0_i    (dec_grant0_o),
        .alloc1_i    (dec_grant1_o),
        .dec0_i      (dec0_i),
        .dec1_i      (dec1_i),
        .sid0_i      (dec_sid0_o),
        .sid1_i      (dec_sid1_o),
        .wb0_i       (wb0_i),
        .wb1_i       (wb1_i),
        .wb_stall0_i (wb_stall0_o),
        .wb_stall1_i (wb_stall1_o),
        .slots_o     (slots)
    );

    scb_issue u_issue (
        .clk          (clk),
        .rst_n        (rst_n),
        .dec0_i       (dec0_i),
        .dec1_i       (dec1_i),
        .slots_i      (slots),
        .alloc0_o     (dec_grant0_o),
        .alloc1_o     (dec_grant1_o),
        .sid0_o       (dec_sid0_o),
        .sid1_o       (dec_sid1_o),
        .dec_stall0_o (dec_stall0_o),
        .dec_stall1_o (dec_stall1_o)
    );

    scb_hazard u_hazard (
        .slots_i     (slots),
        .op0_i       (op0_i),
        .op1_i       (op1_i),
        .wb0_i       (wb0_i),
        .wb1_i       (wb1_i),
        .op_stall0_o (op_stall0_o),
        .op_stall1_o (op_stall1_o),
        .wb_stall0_o (wb_stall0_o),
        .wb_stall1_o (wb_stall1_o)
    );

    scb_flush u_flush (
        .redirect_i   (redirect_i),
        .dec_sid0_i   (dec_sid0_o),
        .dec_sid1_i   (dec_sid1_o),
        .op0_i        (op0_i),
        .op1_i        (op1_i),
        .wb0_i        (wb0_i),
        .wb1_i        (wb1_i),
        .dec_flush0_o (dec_flush0_o),
        .dec_flush1_o (dec_flush1_o),
        .op_flush0_o  (op_flush0_o),
        .op_flush1_o  (op_flush1_o),
        .wb_flush0_o  (wb_flush0_o),
        .wb_flush1_o  (wb_flush1_o)
    );

endmodule

/* scoreboard_tb.sv */
`timescale 1ns/100ps
`include "scb_cfg.svh"

module scoreboard_tb
    import scb_pkg::*;
;

    localparam int RST_TIMEOUT = 20;

    logic clk, rst_n;
    dec_inst_t dec0, dec1;
    op_inst_t op0, op1;
    wb_inst_t wb0, wb1;
    redirect_t redir;
    unit_vec_t grant0, grant1;
    sid_t sid0, sid1;
    logic dst0, dst1, dfl0, dfl1, ost0, ost1, ofl0, ofl1, wst0, wst1, wfl0, wfl1;
    integer seed = 32'hbe7519c7;

    // reference state
    logic m_busy [4];
    logic [4:0] m_rd [4];
    logic [3:0] m_sid [4];
    logic [3:0] m_cnt;
    logic [27:0] exp_now, exp_edge;

    tb_clk_gen u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    scoreboard scoreboard_i (
        .clk(clk), .rst_n(rst_n), .dec0_i(dec0), .dec1_i(dec1), .op0_i(op0), .op1_i(op1),
        .wb0_i(wb0), .wb1_i(wb1), .redirect_i(redir),
        .dec_grant0_o(grant0), .dec_grant1_o(grant1), .dec_sid0_o(sid0), .dec_sid1_o(sid1),
        .dec_stall0_o(dst0), .dec_stall1_o(dst1), .dec_flush0_o(dfl0), .dec_flush1_o(dfl1),
        .op_stall0_o(ost0), .op_stall1_o(ost1), .op_flush0_o(ofl0), .op_flush1_o(ofl1),
        .wb_stall0_o(wst0), .wb_stall1_o(wst1), .wb_flush0_o(wfl0), .wb_flush1_o(wfl1)
    );

    function automatic logic younger(input logic [3:0] a, input logic [3:0] b);
        if (a[3] == b[3]) return a[2:0] > b[2:0];
        return a[2:0] < b[2:0];
    endfunction

    // slot order alu0, alu1, beu, lsu
    function automatic logic [3:0] choose(input dec_inst_t d, input logic [3:0] free);
        logic [3:0] g;
        g = 4'b0;
        if (d.vld && d.exe_unit[`SCB_EU_ALU]) begin
            if (free[0]) g = 4'b0001;
            else if (free[1]) g = 4'b0010;
        end else if (d.vld && d.exe_unit[`SCB_EU_BEU]) begin
            g = {1'b0, free[2], 2'b0};
        end else if (d.vld && d.exe_unit[`SCB_EU_LSU]) begin
            g = {free[3], 3'b0};
        end
        return g;
    endfunction

    function automatic logic src_hit(input op_inst_t o, input logic [4:0] rd);
        return rd == o.rs1 || rd == o.rs2;
    endfunction

    // all outputs packed in port order
    function automatic logic [27:0] expect_outputs();
        logic [3:0] free, g0, g1;
        logic w0, w1, os0, os1;
        free = 4'b0;
        w0 = 1'b0;
        w1 = 1'b0;
        os0 = op1.vld && src_hit(op0, op1.rd) && younger(op0.sid, op1.sid);
        os1 = op0.vld && src_hit(op1, op0.rd) && younger(op1.sid, op0.sid);
        for (int i = 0; i < 4; i++) begin
            free[i] = !m_busy[i];
            if (m_busy[i] && m_rd[i] == dec0.rd) w0 = 1'b1;
            if (m_busy[i] && m_rd[i] == dec1.rd) w1 = 1'b1;
            if (m_busy[i] && src_hit(op0, m_rd[i]) && younger(op0.sid, m_sid[i])) os0 = 1'b1;
            if (m_busy[i] && src_hit(op1, m_rd[i]) && younger(op1.sid, m_sid[i])) os1 = 1'b1;
        end
        g0 = w0 ? 4'b0 : choose(dec0, free);
        g1 = (w1 || (dec0.vld && g0 == 4'b0) || (dec0.vld && dec0.rd == dec1.rd)) ?
             4'b0 : choose(dec1, free & ~g0);
        return {g0, g1, m_cnt, 4'(m_cnt + 1),
                dec0.vld && g0 == 4'b0, dec1.vld && g1 == 4'b0,
                redir.vld && younger(m_cnt, redir.sid),
                redir.vld && younger(4'(m_cnt + 1), redir.sid),
                op0.vld && os0, op1.vld && os1,
                redir.vld && younger(op0.sid, redir.sid),
                redir.vld && younger(op1.sid, redir.sid),
                wb0.vld && wb1.vld && wb0.rd == wb1.rd && younger(wb0.sid, wb1.sid),
                wb0.vld && wb1.vld && wb0.rd == wb1.rd && younger(wb1.sid, wb0.sid),
                redir.vld && younger(wb0.sid, redir.sid),
                redir.vld && younger(wb1.sid, redir.sid)};
    endfunction

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] want);
        if (got !== want) begin
            $display("[FAIL] %s got 0x%0h expected 0x%0h", name, got, want);
            $display("TB FAILED");
            $fatal(1);
        end
    endtask

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            m_cnt <= 4'b0;
            for (int i = 0; i < 4; i++) begin
                m_busy[i] <= 1'b0;
                m_rd[i] <= 5'b0;
                m_sid[i] <= 4'b0;
            end
        end else begin
            exp_edge = expect_outputs();
            for (int i = 0; i < 4; i++) begin
                if (exp_edge[24+i] || exp_edge[20+i]) begin
                    m_busy[i] <= 1'b1;
                    m_rd[i] <= exp_edge[24+i] ? dec0.rd : dec1.rd;
                    m_sid[i] <= exp_edge[24+i] ? exp_edge[19:16] : exp_edge[15:12];
                end else if ((wb0.vld && !exp_edge[3] && wb0.sid == m_sid[i]) ||
                             (wb1.vld && !exp_edge[2] && wb1.sid == m_sid[i])) begin
                    m_busy[i] <= 1'b0;
                end
            end
            if (exp_edge[23:20] != 4'b0) m_cnt <= m_cnt + 2;
            else if (exp_edge[27:24] != 4'b0) m_cnt <= m_cnt + 1;
        end
    end

    // compare just before the next rising edge
    always @(negedge clk) begin
        if (rst_n) begin
            exp_now = expect_outputs();
            check_value("dec_grant0_o", grant0, exp_now[27:24]);
            check_value("dec_grant1_o", grant1, exp_now[23:20]);
            check_value("dec_sid0_o", sid0, exp_now[19:16]);
            check_value("dec_sid1_o", sid1, exp_now[15:12]);
            check_value("dec_stall", {dst0, dst1}, exp_now[11:10]);
            check_value("dec_flush", {dfl0, dfl1}, exp_now[9:8]);
            check_value("op_stall", {ost0, ost1}, exp_now[7:6]);
            check_value("op_flush", {ofl0, ofl1}, exp_now[5:4]);
            check_value("wb_stall", {wst0, wst1}, exp_now[3:2]);
            check_value("wb_flush", {wfl0, wfl1}, exp_now[1:0]);
        end
    end

    function automatic dec_inst_t make_dec(input int unit, input logic [4:0] rd);
        dec_inst_t d;
        d = '0;
        d.vld = 1'b1;
        d.exe_unit[unit] = 1'b1;
        d.rd = rd;
        return d;
    endfunction

    function automatic op_inst_t make_op(input logic [3:0] sid, input logic [4:0] rd,
                                         input logic [4:0] rs1);
        return '{vld: 1'b1, sid: sid, rd: rd, rs1: rs1, rs2: 5'd0};
    endfunction

    task automatic clear_inputs();
        @(posedge clk);
        dec0 <= '0;
        dec1 <= '0;
        op0 <= '0;
        op1 <= '0;
        wb0 <= '0;
        wb1 <= '0;
        redir <= '0;
    endtask

    initial begin
        int n;
        dec0 = '0;
        dec1 = '0;
        op0 = '0;
        op1 = '0;
        wb0 = '0;
        wb1 = '0;
        redir = '0;
        n = 0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
            n++;
            if (n > RST_TIMEOUT) begin
                $display("reset never released");
                $display("TB FAILED");
                $fatal(1);
            end
        end
        // pair of alu ops, then a third one finds no alu
        @(posedge clk);
        dec0 <= make_dec(`SCB_EU_ALU, 5'd1);
        dec1 <= make_dec(`SCB_EU_ALU, 5'd2);
        @(negedge clk);
        check_value("dec_grant0_o", grant0, 32'h1);
        check_value("dec_grant1_o", grant1, 32'h2);
        check_value("dec_sid1_o", sid1, 32'h1);
        @(posedge clk);
        dec0 <= make_dec(`SCB_EU_ALU, 5'd3);
        dec1 <= '0;
        @(negedge clk);
        check_value("dec_sid0_o", sid0, 32'h2);
        check_value("dec_stall0_o", dst0, 32'h1);
        // waw on a busy slot, then lane1 same rd as lane0
        @(posedge clk);
        dec0 <= make_dec(`SCB_EU_LSU, 5'd1);
        @(posedge clk);
        dec0 <= make_dec(`SCB_EU_BEU, 5'd4);
        dec1 <= make_dec(`SCB_EU_LSU, 5'd4);
        @(negedge clk);
        check_value("dec_stall1_o", dst1, 32'h1);
        // release alu0 and reuse it
        @(posedge clk);
        dec0 <= '0;
        dec1 <= '0;
        wb0 <= '{vld: 1'b1, sid: 4'd0, rd: 5'd1};
        @(posedge clk);
        wb0 <= '0;
        dec0 <= make_dec(`SCB_EU_ALU, 5'd5);
        @(posedge clk);
        dec0 <= '0;
        wb0 <= '{vld: 1'b1, sid: 4'd1, rd: 5'd7};
        wb1 <= '{vld: 1'b1, sid: 4'd3, rd: 5'd7};
        @(negedge clk);
        check_value("wb_stall1_o", wst1, 32'h1);
        // operand hazards against beu rd4 and alu0 rd5
        @(posedge clk);
        wb0 <= '0;
        wb1 <= '0;
        op0 <= make_op(4'd4, 5'd9, 5'd5);
        @(negedge clk);
        check_value("op_stall0_o", ost0, 32'h1);
        @(posedge clk);
        op0 <= make_op(4'd5, 5'd10, 5'd11);
        op1 <= make_op(4'd6, 5'd12, 5'd10);
        @(negedge clk);
        check_value("op_stall", {ost0, ost1}, 32'h1);
        // redirect across the wrap bit
        @(posedge clk);
        redir <= '{vld: 1'b1, sid: 4'h6};
        op0 <= make_op(4'h9, 5'd1, 5'd1);
        op1 <= make_op(4'h2, 5'd1, 5'd1);
        @(negedge clk);
        check_value("op_flush", {ofl0, ofl1}, 32'h2);
        clear_inputs();
        repeat (2000) begin
            @(posedge clk);
            dec0 <= '{vld: 1'($random(seed)), exe_unit: 6'(1 << ($random(seed) & 3)),
                      rd: 5'($random(seed) & 7), rs1: 5'($random(seed)), rs2: 5'($random(seed))};
            dec1 <= '{vld: 1'($random(seed)), exe_unit: 6'(1 << ($random(seed) & 3)),
                      rd: 5'($random(seed) & 7), rs1: 5'($random(seed)), rs2: 5'($random(seed))};
            op0 <= '{vld: 1'($random(seed)), sid: 4'($random(seed)), rd: 5'($random(seed) & 7),
                     rs1: 5'($random(seed) & 7), rs2: 5'($random(seed) & 7)};
            op1 <= '{vld: 1'($random(seed)), sid: 4'($random(seed)), rd: 5'($random(seed) & 7),
                     rs1: 5'($random(seed) & 7), rs2: 5'($random(seed) & 7)};
            wb0 <= '{vld: 1'($random(seed)), sid: m_sid[2'($random(seed))],
                     rd: 5'($random(seed) & 3)};
            wb1 <= '{vld: 1'($random(seed)), sid: m_sid[2'($random(seed))],
                     rd: 5'($random(seed) & 3)};
            redir <= '{vld: 1'($random(seed)), sid: 4'($random(seed))};
        end
        clear_inputs();
        @(negedge clk);
        $display("TB PASSED");
        $finish;
    end

endmodule

/* tb_clk_gen.sv */
`timescale 1ns/100ps

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever #50 clk_o = ~clk_o;
    end

    // release on a falling edge, away from the sampling edge
    initial begin
        rst_n_o = 1'b0;
        repeat (3) @(posedge clk_o);
        @(negedge clk_o);
        rst_n_o = 1'b1;
    end

endmodule
